/* Bender.yml */
package:
  name: uart_lite

sources:
  - files:
      - uart_pkg.sv
      - uart_fifo.sv
      - uart_tx_serializer.sv
      - uart_rx_deserializer.sv
      - uart_bus_regs.sv
      - uart_top.sv
  - target: test
    files:
      - tb_uart_top.sv

/* filelist.f */
uart_pkg.sv
uart_fifo.sv
uart_tx_serializer.sv
uart_rx_deserializer.sv
uart_bus_regs.sv
uart_top.sv
tb_uart_top.sv

/* tb_uart_top.sv */
// ======================================================================
// Self-checking testbench for uart_top with bus tasks, serial driver,
// transmit monitor, stimulus table and timeout
// ======================================================================

module tb_uart_top
    import uart_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_ENTRIES    = 16;
    localparam int          TIMEOUT_CYCLES = NUM_ENTRIES * 10 * CLKS_PER_BIT * 3 + 2000;
    localparam logic [31:0] SEED           = 32'hc75e987b;

    // One table row with byte, stop-bit quality and expected DR read
    typedef struct packed {
        logic [7:0]  data;
        logic        good_stop;
        logic [31:0] exp_word;
    } stim_entry_t;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [31:0] i_wb_adr;
    logic [31:0] i_wb_dat;
    logic [31:0] o_wb_dat;
    logic        o_wb_ack;
    logic        i_uart_cts_n;
    logic        i_uart_rxd;
    logic        o_uart_txd;
    logic        o_uart_rts_n;
    logic        o_uart_int;

    stim_entry_t stim [NUM_ENTRIES];
    int          cycle_count;

    uart_top dut_i (.*);

    // 8 ns period
    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    // ==================================================================
    // Run limit
    // ==================================================================

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("TIMEOUT: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge i_clk);
    endtask

    // Write acks in the same cycle as the strobe
    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge i_clk);
        i_wb_stb <= 1'b1;
        i_wb_we  <= 1'b1;
        i_wb_adr <= {16'h0, addr};
        i_wb_dat <= data;
        @(posedge i_clk);
        while (!o_wb_ack)
            @(posedge i_clk);
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
    endtask

    // Read data is valid with the ack one cycle after the strobe
    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        @(posedge i_clk);
        i_wb_stb <= 1'b1;
        i_wb_we  <= 1'b0;
        i_wb_adr <= {16'h0, addr};
        @(posedge i_clk);
        while (!o_wb_ack)
            @(posedge i_clk);
        data = o_wb_dat;
        i_wb_stb <= 1'b0;
    endtask

    // Start, 8 data bits LSB first, stop, then one idle bit
    task automatic send_rx_frame(input logic [7:0] data, input logic good_stop);
        logic [10:0] bits;
        int          b;
        bits = {1'b1, good_stop, data, 1'b0};
        @(posedge i_clk);
        for (b = 0; b < 11; b++)
        begin
            i_uart_rxd <= bits[b];
            wait_cycles(CLKS_PER_BIT);
        end
    endtask

    // Decode one frame on txd by sampling in the middle of each bit
    task automatic capture_tx_frame(input string name, output logic [7:0] data);
        int b;
        @(posedge i_clk);
        while (o_uart_txd !== 1'b0)
            @(posedge i_clk);
        // First low sample is one clock into the start bit
        wait_cycles(HALF_BIT - 1);
        check({name, " start"}, 32'h0, o_uart_txd);
        for (b = 0; b < 8; b++)
        begin
            wait_cycles(CLKS_PER_BIT);
            data[b] = o_uart_txd;
        end
        wait_cycles(CLKS_PER_BIT);
        check({name, " stop"}, 32'h1, o_uart_txd);
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial
    begin
        logic [31:0] rd;
        logic [7:0]  tx_byte;
        int          i;
        int          j;

        cycle_count  = 0;
        i_rst_n      <= 1'b0;
        i_wb_stb     <= 1'b0;
        i_wb_we      <= 1'b0;
        i_wb_adr     <= '0;
        i_wb_dat     <= '0;
        i_uart_cts_n <= 1'b0;
        i_uart_rxd   <= 1'b1;

        // Random bytes with a bad stop bit in every fourth frame
        void'($urandom(SEED));
        for (i = 0; i < NUM_ENTRIES; i++)
        begin
            stim[i].data      = 8'($urandom);
            stim[i].good_stop = (i % 4) != 2;
            stim[i].exp_word  = {23'h0, !stim[i].good_stop, stim[i].data};
        end

        wait_cycles(16);
        i_rst_n <= 1'b1;
        // CTS synchronizer settles
        wait_cycles(8);

        // Reset state and register access
        check("reset txd", 32'h1, o_uart_txd);
        check("reset ack", 32'h0, o_wb_ack);
        check("reset int", 32'h0, o_uart_int);
        check("reset rts_n", 32'h0, o_uart_rts_n);
        bus_read(ADDR_FR, rd);
        check("reset fr", 32'h97, rd);
        bus_write(ADDR_CR, 32'h30);
        bus_read(ADDR_CR, rd);
        check("cr readback", 32'h30, rd);
        bus_read(16'h0004, rd);
        check("unmapped", UNMAPPED_DATA, rd);
        // tx_int_en with empty transmit FIFO
        wait_cycles(2);
        check("tx int", 32'h1, o_uart_int);
        bus_read(ADDR_IIR, rd);
        check("tx int iir", 32'h4, rd);

        // Transmit with writes running ahead of the monitor
        fork
            begin
                for (i = 0; i < NUM_ENTRIES; i++)
                    bus_write(ADDR_DR, {24'h0, stim[i].data});
            end
            begin
                for (j = 0; j < NUM_ENTRIES; j++)
                begin
                    capture_tx_frame($sformatf("tx frame %0d", j), tx_byte);
                    check($sformatf("tx data %0d", j), stim[j].data, tx_byte);
                end
            end
        join
        wait_cycles(CLKS_PER_BIT);
        bus_read(ADDR_FR, rd);
        check("tx drained fr", 32'h97, rd);

        // Only rx_int_en from here on
        bus_write(ADDR_CR, 32'h10);
        wait_cycles(2);
        check("rx int idle", 32'h0, o_uart_int);

        // Receive all frames with no reads in between
        for (i = 0; i < NUM_ENTRIES; i++)
        begin
            send_rx_frame(stim[i].data, stim[i].good_stop);
            check($sformatf("rx int fill %0d", i), (i + 1) >= FIFO_HALF, o_uart_int);
            check($sformatf("rts_n fill %0d", i), (i + 1) == FIFO_DEPTH, o_uart_rts_n);
        end
        bus_read(ADDR_IIR, rd);
        check("rx int iir", 32'h2, rd);

        // Drain in order and watch the levels fall
        for (i = 0; i < NUM_ENTRIES; i++)
        begin
            bus_read(ADDR_DR, rd);
            check($sformatf("rx dr %0d", i), stim[i].exp_word, rd);
            wait_cycles(2);
            check($sformatf("rx int drain %0d", i),
                  (NUM_ENTRIES - 1 - i) >= FIFO_HALF, o_uart_int);
            check($sformatf("rts_n drain %0d", i), 32'h0, o_uart_rts_n);
        end
        bus_read(ADDR_FR, rd);
        check("rx drained fr", 32'h97, rd);

        // CTS inactive holds the transmit line idle
        i_uart_cts_n <= 1'b1;
        wait_cycles(8);
        bus_write(ADDR_DR, {24'h0, stim[0].data});
        bus_read(ADDR_FR, rd);
        check("cts held fr", 32'h1e, rd);
        for (i = 0; i < 3 * CLKS_PER_BIT; i++)
        begin
            @(posedge i_clk);
            check("cts held txd", 32'h1, o_uart_txd);
        end
        i_uart_cts_n <= 1'b0;
        capture_tx_frame("cts frame", tx_byte);
        check("cts data", stim[0].data, tx_byte);

        wait_cycles(4);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* uart_bus_regs.sv */
// ======================================================================
// Bus decode, control register, read data mux and interrupt output
// ======================================================================

module uart_bus_regs
    import uart_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_wb_stb,
    input  logic         i_wb_we,
    input  logic [31:0]  i_wb_adr,
    input  logic [31:0]  i_wb_dat,
    output logic [31:0]  o_wb_dat,
    output logic         o_wb_ack,
    output logic         o_tx_push,
    output uart_byte_t   o_tx_data,
    input  fifo_status_t i_tx_status,
    output logic         o_rx_pop,
    input  rx_word_t     i_rx_head,
    input  fifo_status_t i_rx_status,
    input  logic         i_cts_active,
    output logic         o_uart_int
);

    uart_ctrl_t   cr_q;
    logic [31:0]  rd_data_q;
    logic         read_d1_q;
    logic         int_q;
    logic         start_write;
    logic         start_read;
    logic [15:0]  addr;
    logic         tx_int;
    logic         rx_int;
    logic [7:0]   flags;

    assign addr = i_wb_adr[15:0];

    // ==================================================================
    // Bus handshake
    // ==================================================================

    // A pending read ack goes out before any write
    assign start_write = i_wb_stb && i_wb_we && !read_d1_q;
    assign start_read  = i_wb_stb && !i_wb_we && !o_wb_ack;

    // Writes ack at once, reads one cycle later
    assign o_wb_ack = i_wb_stb && (start_write || read_d1_q);
    assign o_wb_dat = rd_data_q;

    // Side effects on the FIFOs
    assign o_tx_push = start_write && addr == ADDR_DR && !i_tx_status.full;
    assign o_tx_data = i_wb_dat[7:0];
    assign o_rx_pop  = start_read && addr == ADDR_DR;

    // Level interrupts, recomputed every cycle
    assign tx_int     = i_tx_status.at_or_below_half && cr_q.tx_int_en;
    assign rx_int     = i_rx_status.at_or_above_half && cr_q.rx_int_en;
    assign o_uart_int = int_q;

    // PL011-like flag layout, bits 2 and 1 tied high
    assign flags = {i_tx_status.empty, i_rx_status.full, i_tx_status.full,
                    i_rx_status.empty, !i_tx_status.empty, 1'b1, 1'b1, i_cts_active};

    // ==================================================================
    // Control state
    // ==================================================================

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            read_d1_q <= 1'b0;
            cr_q      <= '0;
            int_q     <= 1'b0;
        end
        else
        begin
            read_d1_q <= start_read;
            int_q     <= tx_int || rx_int;
            if (start_write && addr == ADDR_CR)
                cr_q <= uart_ctrl_t'(i_wb_dat[7:0]);
        end
    end

    // Read data, captured as the read starts
    always_ff @(posedge i_clk)
    begin
        if (start_read)
        begin
            case (addr)
                ADDR_DR:  rd_data_q <= {23'd0, i_rx_head};
                ADDR_CR:  rd_data_q <= {24'd0, cr_q};
                ADDR_FR:  rd_data_q <= {24'd0, flags};
                ADDR_IIR: rd_data_q <= {29'd0, tx_int, rx_int, 1'b0};
                default:  rd_data_q <= UNMAPPED_DATA;
            endcase
        end
    end

    // Master holds strobe, so the read ack lands next cycle with no write
    a_read_ack_alone: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        start_read |=> (o_wb_ack && !start_write));

endmodule

/* uart_fifo.sv */
// ======================================================================
// Flip-flop FIFO with head-ahead output, payload type as parameter
// ======================================================================

module uart_fifo
    import uart_pkg::*;
#(
    parameter type T_PAYLOAD = uart_byte_t
)
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_push,
    input  T_PAYLOAD     i_data,
    input  logic         i_pop,
    output T_PAYLOAD     o_head,
    output fifo_status_t o_status
);

    T_PAYLOAD                mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]   wr_ptr_q;
    logic [FIFO_PTR_W-1:0]   rd_ptr_q;
    logic [FIFO_CNT_W-1:0]   count_q;
    logic                    do_push;
    logic                    do_pop;

    // Overflow and underflow requests are dropped here
    assign do_push = i_push && !o_status.full;
    assign do_pop  = i_pop && !o_status.empty;

    assign o_status.empty            = count_q == '0;
    assign o_status.full             = count_q == FIFO_CNT_W'(FIFO_DEPTH);
    assign o_status.at_or_below_half = count_q <= FIFO_CNT_W'(FIFO_HALF);
    assign o_status.at_or_above_half = count_q >= FIFO_CNT_W'(FIFO_HALF);

    // Head is valid whenever not empty
    assign o_head = mem[rd_ptr_q];

    // Storage, no reset needed
    always_ff @(posedge i_clk)
    begin
        if (do_push)
            mem[wr_ptr_q] <= i_data;
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            // Simultaneous push and pop leaves count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        count_q <= FIFO_CNT_W'(FIFO_DEPTH));

    a_empty_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_status.empty && o_status.full));

endmodule

/* uart_pkg.sv */
// ======================================================================
// Shared UART timing constants, register map and packed types
// ======================================================================

package uart_pkg;

    // ==================================================================
    // Serial timing
    // ==================================================================

    // System clocks per serial bit
    localparam int CLKS_PER_BIT = 16;
    // Start edge to middle of start bit
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    // Width of the bit timers
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    // ==================================================================
    // FIFO sizing
    // ==================================================================

    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_HALF    = 8;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
    // One extra bit so that a full count fits
    localparam int FIFO_CNT_W   = FIFO_PTR_W + 1;

    // Register byte addresses, low 16 address bits only
    localparam logic [15:0] ADDR_DR  = 16'h0000;
    localparam logic [15:0] ADDR_CR  = 16'h0014;
    localparam logic [15:0] ADDR_FR  = 16'h0018;
    localparam logic [15:0] ADDR_IIR = 16'h001c;

    // Read value of unknown addresses
    localparam logic [31:0] UNMAPPED_DATA = 32'h00c0ffee;

    // One character
    typedef logic [7:0] uart_byte_t;

    // Received character with its stop-bit check
    typedef struct packed {
        logic       framing_err;
        uart_byte_t data;
    } rx_word_t;

    // Fill state of one FIFO
    typedef struct packed {
        logic empty;
        logic full;
        logic at_or_below_half;
        logic at_or_above_half;
    } fifo_status_t;

    // Control register, 8 raw bits
    typedef struct packed {
        logic [1:0] rsvd_hi;
        logic       tx_int_en;
        logic       rx_int_en;
        logic [3:0] rsvd_lo;
    } uart_ctrl_t;

endpackage

/* uart_rx_deserializer.sv */
// ======================================================================
// Receive side: input filter, start detect, mid-bit sampler, stop check
// ======================================================================

module uart_rx_deserializer
    import uart_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_uart_rxd,
    input  fifo_status_t i_rx_status,
    output logic         o_push,
    output rx_word_t     o_word,
    output logic         o_uart_rts_n
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t             state_q;
    logic [4:0]            rxd_q;
    logic [BIT_CNT_W-1:0]  cnt_q;
    logic [2:0]            bit_idx_q;
    uart_byte_t            data_q;
    rx_word_t              word_q;
    logic                  push_q;
    logic                  rts_n_q;
    logic                  start_seen;
    logic                  rxd_s;
    logic                  half_done;
    logic                  bit_done;

    // Two ones then two zeros, rejects short glitches
    assign start_seen = rxd_q[4:3] == 2'b11 && rxd_q[1:0] == 2'b00;
    // Middle tap lines up with the start detect
    assign rxd_s      = rxd_q[2];

    assign half_done = cnt_q == BIT_CNT_W'(HALF_BIT - 1);
    assign bit_done  = cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1);

    assign o_push       = push_q;
    assign o_word       = word_q;
    assign o_uart_rts_n = rts_n_q;

    // ==================================================================
    // Filter, flow control and sampling FSM
    // ==================================================================

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rxd_q     <= 5'h1f;
            rts_n_q   <= 1'b0;
            state_q   <= RX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            push_q    <= 1'b0;
        end
        else
        begin
            rxd_q   <= {rxd_q[3:0], i_uart_rxd};
            // Ask the far end to hold off while full
            rts_n_q <= i_rx_status.full;
            push_q  <= 1'b0;
            case (state_q)
                RX_IDLE:
                begin
                    cnt_q <= '0;
                    if (start_seen)
                        state_q <= RX_START;
                end
                // Count to the middle of the start bit
                RX_START:
                begin
                    cnt_q <= half_done ? '0 : cnt_q + 1'b1;
                    if (half_done)
                    begin
                        state_q   <= RX_DATA;
                        bit_idx_q <= '0;
                    end
                end
                RX_DATA:
                begin
                    cnt_q <= bit_done ? '0 : cnt_q + 1'b1;
                    if (bit_done)
                    begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7)
                            state_q <= RX_STOP;
                    end
                end
                // Push in mid stop bit, then rearm
                default:
                begin
                    cnt_q <= bit_done ? '0 : cnt_q + 1'b1;
                    if (bit_done)
                    begin
                        state_q <= RX_IDLE;
                        push_q  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Payload shift and output word
    always_ff @(posedge i_clk)
    begin
        if (bit_done && state_q == RX_DATA)
            data_q <= {rxd_s, data_q[7:1]};
        if (bit_done && state_q == RX_STOP)
        begin
            word_q.framing_err <= !rxd_s;
            word_q.data        <= data_q;
        end
    end

    a_push_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_push |=> !o_push);

endmodule

/* uart_top.sv */
// ======================================================================
// UART top level: bus registers, two FIFOs, serializer, deserializer
// ======================================================================

module uart_top
    import uart_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  logic [31:0] i_wb_adr,
    input  logic [31:0] i_wb_dat,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack,
    input  logic        i_uart_cts_n,
    input  logic        i_uart_rxd,
    output logic        o_uart_txd,
    output logic        o_uart_rts_n,
    output logic        o_uart_int
);

    // Transmit path
    logic         tx_push;
    logic         tx_pop;
    uart_byte_t   tx_data;
    uart_byte_t   tx_head;
    fifo_status_t tx_status;
    logic         cts_active;

    // Receive path
    logic         rx_push;
    logic         rx_pop;
    rx_word_t     rx_word;
    rx_word_t     rx_head;
    fifo_status_t rx_status;

    uart_bus_regs regs_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr),
        .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
        .o_tx_push(tx_push), .o_tx_data(tx_data), .i_tx_status(tx_status),
        .o_rx_pop(rx_pop), .i_rx_head(rx_head), .i_rx_status(rx_status),
        .i_cts_active(cts_active), .o_uart_int(o_uart_int)
    );

    uart_fifo #(.T_PAYLOAD(uart_byte_t)) tx_fifo_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_push(tx_push), .i_data(tx_data),
        .i_pop(tx_pop), .o_head(tx_head), .o_status(tx_status)
    );

    uart_tx_serializer tx_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_head(tx_head), .i_status(tx_status), .i_uart_cts_n(i_uart_cts_n),
        .o_pop(tx_pop), .o_cts_active(cts_active), .o_uart_txd(o_uart_txd)
    );

    uart_rx_deserializer rx_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_uart_rxd(i_uart_rxd), .i_rx_status(rx_status),
        .o_push(rx_push), .o_word(rx_word), .o_uart_rts_n(o_uart_rts_n)
    );

    uart_fifo #(.T_PAYLOAD(rx_word_t)) rx_fifo_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_push(rx_push), .i_data(rx_word),
        .i_pop(rx_pop), .o_head(rx_head), .o_status(rx_status)
    );

endmodule

/* uart_tx_serializer.sv */
// ======================================================================
// Transmit side: CTS synchronizer, free bit timer, frame FSM
// ======================================================================

module uart_tx_serializer
    import uart_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  uart_byte_t   i_head,
    input  fifo_status_t i_status,
    input  logic         i_uart_cts_n,
    output logic         o_pop,
    output logic         o_cts_active,
    output logic         o_uart_txd
);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t             state_q;
    logic [BIT_CNT_W-1:0]  timer_q;
    logic [2:0]            bit_idx_q;
    logic [3:0]            cts_n_q;
    uart_byte_t            shift_q;
    logic                  txd_q;
    logic                  bit_tick;
    logic                  pop_tick;
    logic                  frame_go;
    logic                  frame_load;

    // Last clock of each bit time
    assign bit_tick = timer_q == BIT_CNT_W'(CLKS_PER_BIT - 1);
    // One clock earlier, so the FIFO status has settled by the boundary
    assign pop_tick = timer_q == BIT_CNT_W'(CLKS_PER_BIT - 2);

    // CTS must have been low for 3 synchronized cycles
    assign o_cts_active = cts_n_q[3:1] == 3'b000;
    assign frame_go     = o_cts_active && !i_status.empty;
    // CTS only looked at between frames
    assign frame_load   = frame_go && (state_q == TX_IDLE || state_q == TX_STOP);

    assign o_pop      = (state_q == TX_STOP) && pop_tick;
    assign o_uart_txd = txd_q;

    // ==================================================================
    // Synchronizer and bit timer
    // ==================================================================

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cts_n_q <= 4'hf;
            timer_q <= '0;
        end
        else
        begin
            cts_n_q <= {cts_n_q[2:0], i_uart_cts_n};
            timer_q <= bit_tick ? '0 : timer_q + 1'b1;
        end
    end

    // ==================================================================
    // Frame FSM
    // ==================================================================

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state_q   <= TX_IDLE;
            bit_idx_q <= '0;
            txd_q     <= 1'b1;
        end
        else if (bit_tick)
        begin
            case (state_q)
                TX_START:
                begin
                    state_q   <= TX_DATA;
                    bit_idx_q <= '0;
                    txd_q     <= shift_q[0];
                end
                TX_DATA:
                begin
                    if (bit_idx_q == 3'd7)
                    begin
                        state_q <= TX_STOP;
                        txd_q   <= 1'b1;
                    end
                    else
                    begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        txd_q     <= shift_q[1];
                    end
                end
                // Idle and stop both launch the next start bit
                default:
                begin
                    state_q <= frame_load ? TX_START : TX_IDLE;
                    txd_q   <= !frame_load;
                end
            endcase
        end
    end

    // Byte shift register, LSB first
    always_ff @(posedge i_clk)
    begin
        if (bit_tick)
        begin
            if (frame_load)
                shift_q <= i_head;
            else if (state_q == TX_DATA)
                shift_q <= shift_q >> 1;
        end
    end

    a_pop_not_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_pop |-> !i_status.empty);

endmodule
